/* verilog/bank_pkg.sv */
/* Bank geometry and shared types. NUM_BANKS must be a power of two and at least LANES.
   Port addresses are byte addresses; bits above the bank word address do not exist. */
`default_nettype none

package bank_pkg;

  // Bank geometry
  localparam int NUM_BANKS   = 4;
  localparam int LANES       = 2;
  localparam int BANK_DATA_W = 32;
  localparam int BANK_ADDR_W = 8;

  // Byte offset inside a bank word, then the bank select just above it
  localparam int SEL_OFFSET  = 2;
  localparam int SEL_W       = 2;

  // Port byte address covers offset, select and bank word address
  localparam int ADDR_W      = SEL_OFFSET + SEL_W + BANK_ADDR_W;

  // Write lanes take indices 0..LANES-1, read lanes follow
  localparam int NUM_REQ     = 2 * LANES;

  typedef logic [SEL_W-1:0]             bank_sel_t;
  typedef logic [BANK_ADDR_W-1:0]       bank_addr_t;
  typedef logic [BANK_DATA_W-1:0]       bank_data_t;
  typedef logic [BANK_DATA_W/8-1:0]     bank_be_t;
  typedef logic [$clog2(NUM_REQ)-1:0]   req_idx_t;

  // Target of one lane request
  typedef struct packed {
    bank_sel_t  sel;
    bank_addr_t waddr;
  } lane_req_t;

  // Write port payload, one wide word
  typedef struct packed {
    logic [ADDR_W-1:0]           addr;
    bank_data_t [LANES-1:0]      data;
    bank_be_t   [LANES-1:0]      be;
  } wr_port_t;

  // Request to a single bank
  typedef struct packed {
    bank_addr_t addr;
    logic       we;
    bank_data_t wdata;
    bank_be_t   be;
  } bank_req_t;

endpackage

`default_nettype wire

/* verilog/lane_splitter.sv */
/* Splits one port's wide request into LANES bank-word requests.
   The request and its address must stay stable until gnt_o. */
`timescale 1ns/1ps
`default_nettype none

module lane_splitter (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        req_i,
  input  logic [bank_pkg::ADDR_W-1:0]                 addr_i,
  input  logic [bank_pkg::LANES-1:0]                  lane_gnt_i,
  output logic [bank_pkg::LANES-1:0]                  lane_valid_o,
  output bank_pkg::lane_req_t [bank_pkg::LANES-1:0]   lane_o,
  output logic                                        gnt_o
);

  // Lanes already granted for the current word
  logic [bank_pkg::LANES-1:0] done_q;
  logic [bank_pkg::LANES-1:0] lane_done;

  // Byte address of each lane
  logic [bank_pkg::LANES-1:0][bank_pkg::ADDR_W-1:0] lane_addr;

  for (genvar j = 0; j < bank_pkg::LANES; j++) begin : gen_lane
    // Lane j sits j bank words above the port address, wrapping at the top
    assign lane_addr[j] = addr_i + bank_pkg::ADDR_W'((bank_pkg::BANK_DATA_W / 8) * j);

    // Bank select right above the byte offset
    assign lane_o[j].sel =
        lane_addr[j][bank_pkg::SEL_OFFSET +: bank_pkg::SEL_W];
    // Bank word address from the bits above the select
    assign lane_o[j].waddr =
        lane_addr[j][bank_pkg::SEL_OFFSET + bank_pkg::SEL_W +: bank_pkg::BANK_ADDR_W];
  end

  // A granted lane drops out until the whole word is done
  assign lane_valid_o = {bank_pkg::LANES{req_i}} & ~done_q;

  // Lanes done after this cycle's grants
  assign lane_done = done_q | lane_gnt_i;

  // Port grant in the cycle the last outstanding lane is granted
  assign gnt_o = req_i & (&lane_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= '0;
    end else if (gnt_o) begin
      // Word complete, next request starts clean
      done_q <= '0;
    end else if (req_i) begin
      done_q <= lane_done;
    end
  end

endmodule

`default_nettype wire

/* verilog/bank_arbiter.sv */
/* Per-bank round-robin arbitration over all lanes of both ports.
   A bank stays locked to its winner until the bank grants; lanes must hold until granted. */
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic [bank_pkg::NUM_REQ-1:0]                  lane_valid_i,
  input  bank_pkg::lane_req_t [bank_pkg::NUM_REQ-1:0]   lane_i,
  input  logic [bank_pkg::NUM_BANKS-1:0]                bank_gnt_i,
  output logic [bank_pkg::NUM_BANKS-1:0]                bank_req_o,
  output bank_pkg::req_idx_t [bank_pkg::NUM_BANKS-1:0]  winner_o,
  output logic [bank_pkg::NUM_REQ-1:0]                  lane_gnt_o
);

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_bank
    // Lanes that target this bank
    logic [bank_pkg::NUM_REQ-1:0] match;
    // Next index to get priority
    bank_pkg::req_idx_t           rr_q;
    bank_pkg::req_idx_t           rr_idx;
    logic                         rr_found;
    // Lock-in while the bank has not granted
    logic                         lock_q;
    bank_pkg::req_idx_t           lock_idx_q;

    always_comb begin
      for (int i = 0; i < bank_pkg::NUM_REQ; i++) begin
        match[i] = lane_valid_i[i] && (lane_i[i].sel == bank_pkg::bank_sel_t'(b));
      end
    end

    // Round-robin search from rr_q; walking down lets the nearest match win
    always_comb begin
      rr_idx   = rr_q;
      rr_found = 1'b0;
      for (int k = bank_pkg::NUM_REQ - 1; k >= 0; k--) begin
        if (match[(int'(rr_q) + k) % bank_pkg::NUM_REQ]) begin
          rr_idx   = bank_pkg::req_idx_t'((int'(rr_q) + k) % bank_pkg::NUM_REQ);
          rr_found = 1'b1;
        end
      end
    end

    // Locked bank keeps its previous winner
    assign winner_o[b]   = lock_q ? lock_idx_q : rr_idx;
    assign bank_req_o[b] = lock_q ? match[lock_idx_q] : rr_found;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rr_q   <= '0;
        lock_q <= 1'b0;
      end else begin
        // Pending and ungranted, so hold the choice
        lock_q <= bank_req_o[b] && !bank_gnt_i[b];
        // Pointer moves past the winner on a grant
        if (bank_req_o[b] && bank_gnt_i[b]) begin
          rr_q <= bank_pkg::req_idx_t'((int'(winner_o[b]) + 1) % bank_pkg::NUM_REQ);
        end
      end
    end

    // Winner of this cycle, used once the bank locks
    always_ff @(posedge clk_i) begin
      lock_idx_q <= winner_o[b];
    end
  end

  // Lane grant when its bank grants and names it as winner
  always_comb begin
    lane_gnt_o = '0;
    for (int b = 0; b < bank_pkg::NUM_BANKS; b++) begin
      if (bank_req_o[b] && bank_gnt_i[b]) begin
        lane_gnt_o[winner_o[b]] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bank_mux.sv */
/* Builds each bank's request from its winning lane.
   Write data and byte enables come straight from the write port payload. */
`timescale 1ns/1ps
`default_nettype none

module bank_mux (
  input  bank_pkg::req_idx_t [bank_pkg::NUM_BANKS-1:0]  winner_i,
  input  bank_pkg::lane_req_t [bank_pkg::NUM_REQ-1:0]   lane_i,
  input  bank_pkg::wr_port_t                            wr_port_i,
  output bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0] bank_o
);

  // Index width of a write lane
  localparam int LANE_IDX_W = (bank_pkg::LANES > 1) ? $clog2(bank_pkg::LANES) : 1;

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_bank
    logic                  is_wr;
    logic [LANE_IDX_W-1:0] wr_lane;

    // Write lanes sit below LANES in the requester vector
    assign is_wr   = int'(winner_i[b]) < bank_pkg::LANES;
    assign wr_lane = winner_i[b][LANE_IDX_W-1:0];

    always_comb begin
      bank_o[b].addr  = lane_i[winner_i[b]].waddr;
      bank_o[b].we    = is_wr;
      bank_o[b].wdata = '0;
      bank_o[b].be    = '0;
      if (is_wr) begin
        bank_o[b].wdata = wr_port_i.data[wr_lane];
        bank_o[b].be    = wr_port_i.be[wr_lane];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/read_return.sv */
/* Routes bank read data back to the read lanes, MEM_LATENCY cycles after each lane grant.
   No back-pressure: rd_valid_o is a single pulse that must be taken. */
`timescale 1ns/1ps
`default_nettype none

module read_return #(
  parameter int MEM_LATENCY = 1
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic [bank_pkg::LANES-1:0]                   lane_gnt_i,
  input  bank_pkg::lane_req_t [bank_pkg::LANES-1:0]    lane_i,
  input  bank_pkg::bank_data_t [bank_pkg::NUM_BANKS-1:0] bank_rdata_i,
  output logic                                         rd_valid_o,
  output bank_pkg::bank_data_t [bank_pkg::LANES-1:0]   rd_data_o
);

  // One delay line entry: grant seen and the bank it went to
  typedef struct packed {
    logic                valid;
    bank_pkg::bank_sel_t sel;
  } rd_sel_t;

  rd_sel_t [bank_pkg::LANES-1:0][MEM_LATENCY-1:0] shift_q;
  logic    [bank_pkg::LANES-1:0]                  sample;
  logic    [bank_pkg::LANES-1:0]                  filled_q;
  bank_pkg::bank_data_t [bank_pkg::LANES-1:0]     slot_q;

  for (genvar j = 0; j < bank_pkg::LANES; j++) begin : gen_lane
    rd_sel_t tap;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        shift_q[j] <= '0;
      end else begin
        for (int k = MEM_LATENCY - 1; k > 0; k--) begin
          shift_q[j][k] <= shift_q[j][k-1];
        end
        shift_q[j][0] <= '{valid: lane_gnt_i[j], sel: lane_i[j].sel};
      end
    end

    // Bank data is on the bus when the entry leaves the line
    assign tap       = shift_q[j][MEM_LATENCY-1];
    assign sample[j] = tap.valid;

    always_ff @(posedge clk_i) begin
      if (tap.valid) begin
        slot_q[j] <= bank_rdata_i[tap.sel];
      end
    end
  end

  // Whole word present
  assign rd_valid_o = &filled_q;
  assign rd_data_o  = slot_q;

  // A new sample wins over the clear of the finished word
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      filled_q <= '0;
    end else begin
      filled_q <= (rd_valid_o ? '0 : filled_q) | sample;
    end
  end

endmodule

`default_nettype wire

/* verilog/banked_mem_ctrl.sv */
/* Banked memory controller with parallel read and write ports over shared banks.
   Requests hold until their grant; banks must return read data MEM_LATENCY cycles after grant. */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_ctrl #(
  parameter int MEM_LATENCY = 1
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  // Write port
  input  logic                                           wr_req_i,
  input  bank_pkg::wr_port_t                             wr_port_i,
  output logic                                           wr_gnt_o,
  // Read port
  input  logic                                           rd_req_i,
  input  logic [bank_pkg::ADDR_W-1:0]                    rd_addr_i,
  output logic                                           rd_gnt_o,
  output logic                                           rd_valid_o,
  output bank_pkg::bank_data_t [bank_pkg::LANES-1:0]     rd_data_o,
  // Banks
  output logic [bank_pkg::NUM_BANKS-1:0]                 bank_req_o,
  output bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0]  bank_o,
  input  logic [bank_pkg::NUM_BANKS-1:0]                 bank_gnt_i,
  input  bank_pkg::bank_data_t [bank_pkg::NUM_BANKS-1:0] bank_rdata_i
);

  // All lane requesters, write lanes first
  logic [bank_pkg::NUM_REQ-1:0]                 lane_valid;
  bank_pkg::lane_req_t [bank_pkg::NUM_REQ-1:0]  lane;
  logic [bank_pkg::NUM_REQ-1:0]                 lane_gnt;
  bank_pkg::req_idx_t [bank_pkg::NUM_BANKS-1:0] winner;

  lane_splitter i_wr_splitter (
    .clk_i        ( clk_i                             ),
    .reset_i      ( reset_i                           ),
    .req_i        ( wr_req_i                          ),
    .addr_i       ( wr_port_i.addr                    ),
    .lane_gnt_i   ( lane_gnt[bank_pkg::LANES-1:0]     ),
    .lane_valid_o ( lane_valid[bank_pkg::LANES-1:0]   ),
    .lane_o       ( lane[bank_pkg::LANES-1:0]         ),
    .gnt_o        ( wr_gnt_o                          )
  );

  lane_splitter i_rd_splitter (
    .clk_i        ( clk_i                                             ),
    .reset_i      ( reset_i                                           ),
    .req_i        ( rd_req_i                                          ),
    .addr_i       ( rd_addr_i                                         ),
    .lane_gnt_i   ( lane_gnt[bank_pkg::NUM_REQ-1:bank_pkg::LANES]     ),
    .lane_valid_o ( lane_valid[bank_pkg::NUM_REQ-1:bank_pkg::LANES]   ),
    .lane_o       ( lane[bank_pkg::NUM_REQ-1:bank_pkg::LANES]         ),
    .gnt_o        ( rd_gnt_o                                          )
  );

  bank_arbiter i_bank_arbiter (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .lane_valid_i ( lane_valid ),
    .lane_i       ( lane       ),
    .bank_gnt_i   ( bank_gnt_i ),
    .bank_req_o   ( bank_req_o ),
    .winner_o     ( winner     ),
    .lane_gnt_o   ( lane_gnt   )
  );

  bank_mux i_bank_mux (
    .winner_i  ( winner    ),
    .lane_i    ( lane      ),
    .wr_port_i ( wr_port_i ),
    .bank_o    ( bank_o    )
  );

  // Only the read lanes feed the return path
  read_return #(
    .MEM_LATENCY ( MEM_LATENCY )
  ) i_read_return (
    .clk_i        ( clk_i                                         ),
    .reset_i      ( reset_i                                       ),
    .lane_gnt_i   ( lane_gnt[bank_pkg::NUM_REQ-1:bank_pkg::LANES] ),
    .lane_i       ( lane[bank_pkg::NUM_REQ-1:bank_pkg::LANES]     ),
    .bank_rdata_i ( bank_rdata_i                                  ),
    .rd_valid_o   ( rd_valid_o                                    ),
    .rd_data_o    ( rd_data_o                                     )
  );

endmodule

`default_nettype wire

/* test/banked_mem_ctrl_properties.sv */
/* Checks on the bank arbiter: lock-in of the winner and its request, one lane grant per
   granting bank, and waiting lanes holding their requests. */
`timescale 1ns/1ps
`default_nettype none

module banked_mem_ctrl_properties (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input logic [bank_pkg::NUM_REQ-1:0]                  lane_valid_i,
  input logic [bank_pkg::NUM_BANKS-1:0]                bank_gnt_i,
  input logic [bank_pkg::NUM_BANKS-1:0]                bank_req_i,
  input bank_pkg::req_idx_t [bank_pkg::NUM_BANKS-1:0]  winner_i,
  input logic [bank_pkg::NUM_REQ-1:0]                  lane_gnt_i
);

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_bank
    // Pending request without grant stays up and keeps its winner
    winner_held: assert property (@(posedge clk_i) disable iff (reset_i)
        bank_req_i[b] && !bank_gnt_i[b] |=> bank_req_i[b] && winner_i[b] == $past(winner_i[b]))
      else $error("Bank %0d dropped or changed its request while it was pending", b);
  end

  // Each granting bank grants exactly one lane, no lane granted twice
  lane_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $countones(lane_gnt_i) == $countones(bank_req_i & bank_gnt_i))
    else $error("Lane grants do not match the granting banks one to one");

  for (genvar i = 0; i < bank_pkg::NUM_REQ; i++) begin : gen_lane
    // A waiting lane keeps requesting until its bank grants it
    lane_held: assert property (@(posedge clk_i) disable iff (reset_i)
        lane_valid_i[i] && !lane_gnt_i[i] |=> lane_valid_i[i])
      else $error("Lane %0d dropped its request before it was granted", i);
  end

endmodule

bind bank_arbiter banked_mem_ctrl_properties i_banked_mem_ctrl_properties (
  .clk_i        ( clk_i        ),
  .reset_i      ( reset_i      ),
  .lane_valid_i ( lane_valid_i ),
  .bank_gnt_i   ( bank_gnt_i   ),
  .bank_req_i   ( bank_req_o   ),
  .winner_i     ( winner_o     ),
  .lane_gnt_i   ( lane_gnt_o   )
);

`default_nettype wire

/* test/tb_banked_mem_ctrl.sv */
/* Directed tests against a single-ported bank model and a reference memory.
   Banks grant at once unless stall mode is on; read data follows MEM_LATENCY cycles later. */
`timescale 1ns/1ps
`default_nettype none

module tb_banked_mem_ctrl;

  localparam int MEM_LATENCY    = 1;
  localparam int RANDOM_OPS     = 40;
  localparam int DIRECTED_OPS   = 20;
  // Generous bound per operation with stalls, plus reset
  localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * 64 + 160;
  localparam int NUM_WORDS      = 1 << (bank_pkg::ADDR_W - bank_pkg::SEL_OFFSET);
  localparam int BANK_WORDS     = 1 << bank_pkg::BANK_ADDR_W;

  logic                                           clk = 1'b0;
  logic                                           reset;
  logic                                           wr_req;
  bank_pkg::wr_port_t                             wr_port;
  logic                                           wr_gnt;
  logic                                           rd_req;
  logic [bank_pkg::ADDR_W-1:0]                    rd_addr;
  logic                                           rd_gnt;
  logic                                           rd_valid;
  bank_pkg::bank_data_t [bank_pkg::LANES-1:0]     rd_data;
  logic [bank_pkg::NUM_BANKS-1:0]                 bank_req;
  bank_pkg::bank_req_t [bank_pkg::NUM_BANKS-1:0]  bank;
  logic [bank_pkg::NUM_BANKS-1:0]                 bank_gnt;
  bank_pkg::bank_data_t [bank_pkg::NUM_BANKS-1:0] bank_rdata;

  bank_pkg::bank_data_t bank_mem [bank_pkg::NUM_BANKS][BANK_WORDS];
  bank_pkg::bank_data_t rd_pipe  [bank_pkg::NUM_BANKS][MEM_LATENCY];
  // Reference memory, one entry per bank word in port order
  bank_pkg::bank_data_t ref_mem  [NUM_WORDS];
  logic                 stall_mode;
  logic [31:0]          stim_lfsr  = 32'h7b5c;
  logic [31:0]          stall_lfsr = 32'h7b5c;
  int                   errors     = 0;
  int                   checks     = 0;
  int                   cycle_cnt  = 0;

  banked_mem_ctrl #(
    .MEM_LATENCY ( MEM_LATENCY )
  ) i_banked_mem_ctrl (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .wr_req_i     ( wr_req     ),
    .wr_port_i    ( wr_port    ),
    .wr_gnt_o     ( wr_gnt     ),
    .rd_req_i     ( rd_req     ),
    .rd_addr_i    ( rd_addr    ),
    .rd_gnt_o     ( rd_gnt     ),
    .rd_valid_o   ( rd_valid   ),
    .rd_data_o    ( rd_data    ),
    .bank_req_o   ( bank_req   ),
    .bank_o       ( bank       ),
    .bank_gnt_i   ( bank_gnt   ),
    .bank_rdata_i ( bank_rdata )
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Initial content, distinct for every word index
  function automatic bank_pkg::bank_data_t fill_word(input int w);
    return 32'h5a5a_0000 ^ (32'(w) * 32'h9e37_79b1);
  endfunction

  // Word index of lane j: consecutive bank words, wrapping at the top
  function automatic int word_of(input logic [bank_pkg::ADDR_W-1:0] addr, input int j);
    return (int'(addr >> bank_pkg::SEL_OFFSET) + j) % NUM_WORDS;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      val       = {val[30:0], stim_lfsr[0]};
    end
  endtask

  for (genvar b = 0; b < bank_pkg::NUM_BANKS; b++) begin : gen_rdata
    assign bank_rdata[b] = rd_pipe[b][MEM_LATENCY-1];
  end

  // Bank model: word index w lives in bank w % NUM_BANKS at w / NUM_BANKS
  always @(posedge clk) begin
    logic [bank_pkg::NUM_BANKS-1:0] gnt_next;
    bank_pkg::bank_data_t           word;
    gnt_next = '1;
    for (int b = 0; b < bank_pkg::NUM_BANKS; b++) begin
      for (int k = 1; k < MEM_LATENCY; k++) begin
        rd_pipe[b][k] <= rd_pipe[b][k-1];
      end
      if (bank_req[b] && bank_gnt[b]) begin
        word = bank_mem[b][bank[b].addr];
        if (bank[b].we) begin
          for (int k = 0; k < 4; k++) begin
            if (bank[b].be[k]) begin
              word[8*k +: 8] = bank[b].wdata[8*k +: 8];
            end
          end
          bank_mem[b][bank[b].addr] = word;
        end else begin
          rd_pipe[b][0] <= word;
        end
      end
      if (stall_mode) begin
        stall_lfsr  = lfsr_step(stall_lfsr);
        gnt_next[b] = stall_lfsr[0];
      end
    end
    bank_gnt <= gnt_next;
  end

  // Reference memory follows every granted write
  always @(posedge clk) begin
    if (wr_gnt) begin
      for (int j = 0; j < bank_pkg::LANES; j++) begin
        for (int k = 0; k < 4; k++) begin
          if (wr_port.be[j][k]) begin
            ref_mem[word_of(wr_port.addr, j)][8*k +: 8] = wr_port.data[j][8*k +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic compare_word(input bank_pkg::bank_data_t got, input bank_pkg::bank_data_t exp,
                              input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle(input string phase);
    checks++;
    assert (!wr_gnt && !rd_gnt && !rd_valid && bank_req == '0) else begin
      errors++;
      $display("Error at %0t ns: outputs active %s reset", $time, phase);
    end
  endtask

  task automatic write_word(input logic [bank_pkg::ADDR_W-1:0] addr,
                            input bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data,
                            input bank_pkg::bank_be_t [bank_pkg::LANES-1:0] be);
    @(posedge clk);
    wr_req       <= 1'b1;
    wr_port.addr <= addr;
    wr_port.data <= data;
    wr_port.be   <= be;
    do begin
      @(posedge clk);
    end while (!wr_gnt);
    wr_req <= 1'b0;
  endtask

  // Expected data is taken from the reference memory when the read is issued
  task automatic read_word(input logic [bank_pkg::ADDR_W-1:0] addr, input logic check_latency,
                           input string what);
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] exp;
    int                                         wait_cycles;
    @(posedge clk);
    for (int j = 0; j < bank_pkg::LANES; j++) begin
      exp[j] = ref_mem[word_of(addr, j)];
    end
    rd_req  <= 1'b1;
    rd_addr <= addr;
    do begin
      @(posedge clk);
    end while (!rd_gnt);
    rd_req      <= 1'b0;
    wait_cycles = 0;
    do begin
      @(posedge clk);
      wait_cycles++;
    end while (!rd_valid);
    if (check_latency) begin
      checks++;
      assert (wait_cycles == MEM_LATENCY + 1) else begin
        errors++;
        $display("Error at %0t ns: %s valid after %0d cycles, expected %0d", $time, what,
                 wait_cycles, MEM_LATENCY + 1);
      end
    end
    for (int j = 0; j < bank_pkg::LANES; j++) begin
      compare_word(rd_data[j], exp[j], what);
    end
  endtask

  task automatic test_reset();
    @(posedge clk);
    repeat (9) begin
      @(posedge clk);
      check_idle("during");
    end
    reset <= 1'b0;
    @(posedge clk);
    check_idle("after");
  endtask

  task automatic test_write_read();
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data;
    for (int i = 0; i < 4; i++) begin
      data[0] = 32'hc0de_0000 + 32'(2 * i);
      data[1] = 32'hc0de_0001 + 32'(2 * i);
      write_word(bank_pkg::ADDR_W'(12'h100 + 8 * i), data, '1);
    end
    for (int i = 0; i < 4; i++) begin
      read_word(bank_pkg::ADDR_W'(12'h100 + 8 * i), 1'b1, "write-read");
    end
    // Word pair straddling two written words
    read_word(12'h10c, 1'b1, "straddled read");
  endtask

  task automatic test_byte_enables();
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data;
    data = {32'h4444_3333, 32'h2222_1111};
    write_word(12'h200, data, '1);
    data = {32'hddcc_bbaa, 32'h9988_7766};
    write_word(12'h200, data, {4'b0101, 4'b1000});
    read_word(12'h200, 1'b1, "byte-enable read");
  endtask

  // Both ports hit banks 0 and 1 in the same cycle
  task automatic test_contention();
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data;
    data = {32'hfeed_0001, 32'hfeed_0000};
    fork
      write_word(12'h300, data, '1);
      read_word(12'h340, 1'b0, "contended read");
    join
    read_word(12'h300, 1'b1, "contended write readback");
  endtask

  task automatic test_stalls();
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data;
    logic [bank_pkg::ADDR_W-1:0]                addr;
    logic [31:0]                                r;
    @(posedge clk);
    stall_mode <= 1'b1;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      // Small region so reads often hit earlier writes
      take_bits(6, r);
      addr = bank_pkg::ADDR_W'({r[5:0], 2'b00});
      take_bits(1, r);
      if (r[0]) begin
        take_bits(32, r);
        data[0] = r;
        take_bits(32, r);
        data[1] = r;
        take_bits(8, r);
        write_word(addr, data, r[7:0]);
      end else begin
        read_word(addr, 1'b0, "stalled read");
      end
    end
    @(posedge clk);
    stall_mode <= 1'b0;
  endtask

  task automatic test_wrap();
    bank_pkg::bank_data_t [bank_pkg::LANES-1:0] data;
    data = {32'h0def_0000, 32'h0def_0ffc};
    write_word(12'hffc, data, '1);
    read_word(12'hffc, 1'b1, "wrapped read");
    // Lane 0 at bank 3 top word, lane 1 wrapped to bank 0 word 0
    compare_word(bank_mem[3][BANK_WORDS-1], data[0], "wrap lane 0 target");
    compare_word(bank_mem[0][0], data[1], "wrap lane 1 target");
    read_word(12'h000, 1'b1, "read at wrapped word");
  endtask

  initial begin
    for (int w = 0; w < NUM_WORDS; w++) begin
      ref_mem[w] = fill_word(w);
    end
    for (int b = 0; b < bank_pkg::NUM_BANKS; b++) begin
      for (int a = 0; a < BANK_WORDS; a++) begin
        bank_mem[b][a] = fill_word(a * bank_pkg::NUM_BANKS + b);
      end
      for (int k = 0; k < MEM_LATENCY; k++) begin
        rd_pipe[b][k] <= '0;
      end
    end
    reset      <= 1'b1;
    wr_req     <= 1'b0;
    wr_port    <= '0;
    rd_req     <= 1'b0;
    rd_addr    <= '0;
    bank_gnt   <= '1;
    stall_mode <= 1'b0;

    test_reset();
    test_write_read();
    test_byte_enables();
    test_contention();
    test_stalls();
    test_wrap();

    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/bank_pkg.sv
verilog/lane_splitter.sv
verilog/bank_arbiter.sv
verilog/bank_mux.sv
verilog/read_return.sv
verilog/banked_mem_ctrl.sv
test/banked_mem_ctrl_properties.sv
test/tb_banked_mem_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_banked_mem_ctrl \
  -f sources.f -Mdir obj_dir -o sim_tb \
  || { echo "Build failed"; exit 1; }

./obj_dir/sim_tb 2>&1 | tee sim.log

grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
